// File: logic/mem_sys_defines.svh
`ifndef MEM_SYS_DEFINES_SVH
`define MEM_SYS_DEFINES_SVH

// async SRAM part is halfword wide with upper and lower byte lanes.
`define SRAM_ADDR_W 20
`define SRAM_DATA_W 16

// request port.
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// reserved test-point address. writes here never reach the SRAM.
`define TP_ADDR 32'hFFFF_FFF0

`endif

// File: logic/mem_sys_pkg.sv
`include "mem_sys_defines.svh"

package mem_sys_pkg;

    // one SRAM halfword and its address.
    typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;
    typedef logic [`SRAM_DATA_W-1:0] sram_data_t;

    // shared by both sequencers.
    // LO and HI each cover one halfword access.
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LO   = 2'd1,
        HI   = 2'd2
    } seq_state_t;

endpackage

// File: logic/sram_read_seq.sv
`timescale 1ns/1ns
`include "mem_sys_defines.svh"

module sram_read_seq
    import mem_sys_pkg::*;
(
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_req_valid,
    input  logic                   i_req_we,
    input  logic [`BUS_ADDR_W-1:0] i_req_addr,
    input  sram_data_t             i_rd_dq,
    output logic                   o_pin_req,
    output sram_addr_t             o_addr,
    output logic                   o_ce_n,
    output logic                   o_oe_n,
    output logic                   o_lb_n,
    output logic                   o_ub_n,
    output logic                   o_busy,
    output logic                   o_rd_done,
    output logic [`BUS_DATA_W-1:0] o_rd_data
);

    seq_state_t                 state;
    logic [`SRAM_ADDR_W-2:0]    word_addr;
    logic                       sample_lo;  // low halfword on the bus this edge.
    logic                       sample_hi;
    logic [`BUS_DATA_W-1:0]     rd_data;
    logic                       accept;

    assign accept = i_req_valid & ~i_req_we & (state == IDLE);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state     <= IDLE;
            sample_lo <= 1'b0;
            sample_hi <= 1'b0;
            o_rd_done <= 1'b0;
        end else begin
            case (state)
                IDLE:    if (accept) state <= LO;
                LO:      state <= HI;
                HI:      state <= IDLE;
                default: state <= IDLE;
            endcase
            // pins are registered in the mux, so data trails the state by one edge.
            sample_lo <= (state == LO);
            sample_hi <= sample_lo;
            o_rd_done <= sample_hi;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            word_addr <= i_req_addr[`SRAM_ADDR_W:2];
        end
        if (sample_lo) begin
            rd_data[`SRAM_DATA_W-1:0] <= i_rd_dq;
        end
        if (sample_hi) begin
            rd_data[`BUS_DATA_W-1:`SRAM_DATA_W] <= i_rd_dq;
        end
    end

    // both lanes on for the whole access.
    always_comb begin
        o_pin_req = (state != IDLE);
        o_addr    = {word_addr, state == HI};
        o_ce_n    = ~o_pin_req;
        o_oe_n    = ~o_pin_req;
        o_lb_n    = ~o_pin_req;
        o_ub_n    = ~o_pin_req;
    end

    assign o_busy    = (state != IDLE) | sample_lo | sample_hi;
    assign o_rd_data = rd_data;

endmodule

// File: logic/sram_write_seq.sv
`timescale 1ns/1ns
`include "mem_sys_defines.svh"

module sram_write_seq
    import mem_sys_pkg::*;
(
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_req_valid,
    input  logic                   i_req_we,
    input  logic [`BUS_ADDR_W-1:0] i_req_addr,
    input  logic [`BUS_DATA_W-1:0] i_req_wdata,
    input  logic [3:0]             i_req_be,
    output logic                   o_pin_req,
    output sram_addr_t             o_addr,
    output logic                   o_ce_n,
    output logic                   o_we_n,
    output logic                   o_lb_n,
    output logic                   o_ub_n,
    output sram_data_t             o_wr_dq,
    output logic                   o_busy,
    output logic                   o_wr_done,
    output logic [`BUS_DATA_W-1:0] o_sim_tp
);

    seq_state_t                 state;
    logic [`SRAM_ADDR_W-2:0]    word_addr;
    logic [`BUS_DATA_W-1:0]     wdata_q;
    logic [3:0]                 be_q;
    logic                       tp_pend;
    logic                       is_tp;
    logic                       accept;

    assign is_tp  = (i_req_addr == `TP_ADDR);
    assign accept = i_req_valid & i_req_we & (state == IDLE) & ~tp_pend;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state     <= IDLE;
            tp_pend   <= 1'b0;
            o_wr_done <= 1'b0;
            o_sim_tp  <= '0;
        end else begin
            case (state)
                IDLE:    if (accept && !is_tp) state <= LO;
                LO:      state <= HI;
                HI:      state <= IDLE;
                default: state <= IDLE;
            endcase
            tp_pend   <= accept & is_tp;
            // test-point writes finish right away, SRAM writes after the high half.
            o_wr_done <= (accept & is_tp) | (state == HI);
            if (tp_pend) begin
                o_sim_tp <= wdata_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            word_addr <= i_req_addr[`SRAM_ADDR_W:2];
            wdata_q   <= i_req_wdata;
            be_q      <= i_req_be;
        end
    end

    always_comb begin
        o_pin_req = (state != IDLE);
        o_addr    = {word_addr, state == HI};
        o_ce_n    = ~o_pin_req;
        o_we_n    = ~o_pin_req;
        o_lb_n    = 1'b1;
        o_ub_n    = 1'b1;
        o_wr_dq   = wdata_q[`SRAM_DATA_W-1:0];
        case (state)
            LO: begin
                o_lb_n = ~be_q[0];
                o_ub_n = ~be_q[1];
            end
            HI: begin
                o_lb_n  = ~be_q[2];
                o_ub_n  = ~be_q[3];
                o_wr_dq = wdata_q[`BUS_DATA_W-1:`SRAM_DATA_W];
            end
            default: ;  // lanes stay off.
        endcase
    end

    assign o_busy = (state != IDLE) | tp_pend;

endmodule

// File: logic/sram_pin_mux.sv
`timescale 1ns/1ns

module sram_pin_mux
    import mem_sys_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_rd_pin_req,
    input  sram_addr_t i_rd_addr,
    input  logic       i_rd_ce_n,
    input  logic       i_rd_oe_n,
    input  logic       i_rd_lb_n,
    input  logic       i_rd_ub_n,
    input  logic       i_rd_busy,
    input  logic       i_rd_done,
    input  logic       i_wr_pin_req,
    input  sram_addr_t i_wr_addr,
    input  logic       i_wr_ce_n,
    input  logic       i_wr_we_n,
    input  logic       i_wr_lb_n,
    input  logic       i_wr_ub_n,
    input  sram_data_t i_wr_dq,
    input  logic       i_wr_busy,
    input  logic       i_wr_done,
    output sram_addr_t o_sram_addr,
    output logic       o_sram_ce_n,
    output logic       o_sram_oe_n,
    output logic       o_sram_we_n,
    output logic       o_sram_lb_n,
    output logic       o_sram_ub_n,
    output sram_data_t o_dq_out,
    output logic       o_dq_oe,
    output logic       o_busy,
    output logic       o_sim_retire
);

    sram_addr_t sel_addr;
    logic       sel_ce_n;
    logic       sel_oe_n;
    logic       sel_we_n;
    logic       sel_lb_n;
    logic       sel_ub_n;

    // park everything inactive unless a sequencer holds the pins.
    always_comb begin
        sel_addr = i_rd_addr;
        sel_ce_n = 1'b1;
        sel_oe_n = 1'b1;
        sel_we_n = 1'b1;
        sel_lb_n = 1'b1;
        sel_ub_n = 1'b1;
        if (i_wr_pin_req) begin
            sel_addr = i_wr_addr;
            sel_ce_n = i_wr_ce_n;
            sel_we_n = i_wr_we_n;
            sel_lb_n = i_wr_lb_n;
            sel_ub_n = i_wr_ub_n;
        end else if (i_rd_pin_req) begin
            sel_ce_n = i_rd_ce_n;
            sel_oe_n = i_rd_oe_n;
            sel_lb_n = i_rd_lb_n;
            sel_ub_n = i_rd_ub_n;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_sram_ce_n  <= 1'b1;
            o_sram_oe_n  <= 1'b1;
            o_sram_we_n  <= 1'b1;
            o_sram_lb_n  <= 1'b1;
            o_sram_ub_n  <= 1'b1;
            o_dq_oe      <= 1'b0;
            o_sim_retire <= 1'b0;
        end else begin
            o_sram_ce_n  <= sel_ce_n;
            o_sram_oe_n  <= sel_oe_n;
            o_sram_we_n  <= sel_we_n;
            o_sram_lb_n  <= sel_lb_n;
            o_sram_ub_n  <= sel_ub_n;
            o_dq_oe      <= i_wr_pin_req;  // lines up with we_n low.
            o_sim_retire <= i_wr_done;
        end
    end

    always_ff @(posedge clk) begin
        o_sram_addr <= sel_addr;
        o_dq_out    <= i_wr_dq;
    end

    // done pulses keep the port busy until the response has gone out.
    assign o_busy = i_rd_busy | i_wr_busy | i_rd_done | i_wr_done;

endmodule

// File: logic/mem_sys_top.sv
`timescale 1ns/1ns
`include "mem_sys_defines.svh"

module mem_sys_top
    import mem_sys_pkg::*;
(
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_req_valid,
    input  logic                    i_req_we,
    input  logic [`BUS_ADDR_W-1:0]  i_req_addr,
    input  logic [`BUS_DATA_W-1:0]  i_req_wdata,
    input  logic [3:0]              i_req_be,
    inout  wire [`SRAM_DATA_W-1:0]  io_sram_dq,
    output sram_addr_t              o_sram_addr,
    output logic                    o_sram_ce_n,
    output logic                    o_sram_oe_n,
    output logic                    o_sram_we_n,
    output logic                    o_sram_lb_n,
    output logic                    o_sram_ub_n,
    output logic                    o_rsp_valid,
    output logic [`BUS_DATA_W-1:0]  o_rsp_rdata,
    output logic                    o_busy,
    output logic [`BUS_DATA_W-1:0]  o_sim_tp,
    output logic                    o_sim_retire
);

    logic       req_go;
    logic       rd_pin_req, rd_ce_n, rd_oe_n, rd_lb_n, rd_ub_n, rd_busy, rd_done;
    sram_addr_t rd_addr;
    logic       wr_pin_req, wr_ce_n, wr_we_n, wr_lb_n, wr_ub_n, wr_busy, wr_done;
    sram_addr_t wr_addr;
    sram_data_t wr_dq;
    sram_data_t dq_out;
    logic       dq_oe;

    // strobes while busy are dropped here so neither sequencer sees them.
    assign req_go = i_req_valid & ~o_busy;

    sram_read_seq u_read_seq (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (req_go),
        .i_req_we    (i_req_we),
        .i_req_addr  (i_req_addr),
        .i_rd_dq     (io_sram_dq),
        .o_pin_req   (rd_pin_req),
        .o_addr      (rd_addr),
        .o_ce_n      (rd_ce_n),
        .o_oe_n      (rd_oe_n),
        .o_lb_n      (rd_lb_n),
        .o_ub_n      (rd_ub_n),
        .o_busy      (rd_busy),
        .o_rd_done   (rd_done),
        .o_rd_data   (o_rsp_rdata)
    );

    sram_write_seq u_write_seq (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (req_go),
        .i_req_we    (i_req_we),
        .i_req_addr  (i_req_addr),
        .i_req_wdata (i_req_wdata),
        .i_req_be    (i_req_be),
        .o_pin_req   (wr_pin_req),
        .o_addr      (wr_addr),
        .o_ce_n      (wr_ce_n),
        .o_we_n      (wr_we_n),
        .o_lb_n      (wr_lb_n),
        .o_ub_n      (wr_ub_n),
        .o_wr_dq     (wr_dq),
        .o_busy      (wr_busy),
        .o_wr_done   (wr_done),
        .o_sim_tp    (o_sim_tp)
    );

    sram_pin_mux u_pin_mux (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_rd_pin_req (rd_pin_req),
        .i_rd_addr    (rd_addr),
        .i_rd_ce_n    (rd_ce_n),
        .i_rd_oe_n    (rd_oe_n),
        .i_rd_lb_n    (rd_lb_n),
        .i_rd_ub_n    (rd_ub_n),
        .i_rd_busy    (rd_busy),
        .i_rd_done    (rd_done),
        .i_wr_pin_req (wr_pin_req),
        .i_wr_addr    (wr_addr),
        .i_wr_ce_n    (wr_ce_n),
        .i_wr_we_n    (wr_we_n),
        .i_wr_lb_n    (wr_lb_n),
        .i_wr_ub_n    (wr_ub_n),
        .i_wr_dq      (wr_dq),
        .i_wr_busy    (wr_busy),
        .i_wr_done    (wr_done),
        .o_sram_addr  (o_sram_addr),
        .o_sram_ce_n  (o_sram_ce_n),
        .o_sram_oe_n  (o_sram_oe_n),
        .o_sram_we_n  (o_sram_we_n),
        .o_sram_lb_n  (o_sram_lb_n),
        .o_sram_ub_n  (o_sram_ub_n),
        .o_dq_out     (dq_out),
        .o_dq_oe      (dq_oe),
        .o_busy       (o_busy),
        .o_sim_retire (o_sim_retire)
    );

    assign io_sram_dq  = dq_oe ? dq_out : 'z;
    assign o_rsp_valid = rd_done;

endmodule

// File: logic/sim_dut.sv
`timescale 1ns/1ns
`include "mem_sys_defines.svh"

module sim_dut
    import mem_sys_pkg::*;
(
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_req_valid,
    input  logic                    i_req_we,
    input  logic [`BUS_ADDR_W-1:0]  i_req_addr,
    input  logic [`BUS_DATA_W-1:0]  i_req_wdata,
    input  logic [3:0]              i_req_be,
    input  sram_data_t              i_sram_dq,
    output sram_data_t              o_sram_dq,
    output sram_addr_t              o_sram_addr,
    output logic                    o_sram_ce_n,
    output logic                    o_sram_oe_n,
    output logic                    o_sram_we_n,
    output logic                    o_sram_ub_n,
    output logic                    o_sram_lb_n,
    output logic                    o_rsp_valid,
    output logic [`BUS_DATA_W-1:0]  o_rsp_rdata,
    output logic                    o_busy,
    output logic [`BUS_DATA_W-1:0]  o_sim_tp,
    output logic                    o_sim_retire
);

    logic                    sram_we_n;
    wire [`SRAM_DATA_W-1:0]  sram_dq;

    // memory model owns the bus except while a write is on the pins.
    assign sram_dq     = sram_we_n ? i_sram_dq : 'z;
    assign o_sram_dq   = sram_dq;
    assign o_sram_we_n = sram_we_n;

    mem_sys_top u_mem_sys_top (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_req_valid  (i_req_valid),
        .i_req_we     (i_req_we),
        .i_req_addr   (i_req_addr),
        .i_req_wdata  (i_req_wdata),
        .i_req_be     (i_req_be),
        .io_sram_dq   (sram_dq),
        .o_sram_addr  (o_sram_addr),
        .o_sram_ce_n  (o_sram_ce_n),
        .o_sram_oe_n  (o_sram_oe_n),
        .o_sram_we_n  (sram_we_n),
        .o_sram_lb_n  (o_sram_lb_n),
        .o_sram_ub_n  (o_sram_ub_n),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp_rdata  (o_rsp_rdata),
        .o_busy       (o_busy),
        .o_sim_tp     (o_sim_tp),
        .o_sim_retire (o_sim_retire)
    );

endmodule

// File: verification/sram_model.sv
`timescale 1ns/1ns
`include "mem_sys_defines.svh"

module sram_model (
    input  logic                    clk,
    input  logic [`SRAM_ADDR_W-1:0] i_addr,
    input  logic                    i_ce_n,
    input  logic                    i_oe_n,
    input  logic                    i_we_n,
    input  logic                    i_lb_n,
    input  logic                    i_ub_n,
    input  logic [`SRAM_DATA_W-1:0] i_dq,
    output logic [`SRAM_DATA_W-1:0] o_dq
);

    logic [`SRAM_DATA_W-1:0] mem [0:(1 << `SRAM_ADDR_W)-1];

    // power-up content differs for every halfword address.
    initial begin
        for (int a = 0; a < (1 << `SRAM_ADDR_W); a++) begin
            mem[a] = a[15:0] ^ {4{a[19:16]}} ^ 16'hA5C3;
        end
    end

    // asynchronous read releases the bus while not selected.
    assign o_dq = (!i_ce_n && !i_oe_n) ? mem[i_addr] : 'z;

    always @(posedge clk) begin
        if (!i_ce_n && !i_we_n) begin
            if (!i_lb_n) mem[i_addr][7:0] = i_dq[7:0];    // lower lane.
            if (!i_ub_n) mem[i_addr][15:8] = i_dq[15:8];
        end
    end

endmodule

// File: verification/tb_sim_dut.sv
`timescale 1ns/1ns
`include "mem_sys_defines.svh"

module tb_sim_dut
    import mem_sys_pkg::*;
();

    localparam int          CLK_PERIOD = 20;
    localparam int          NUM_REQ    = 8 + 24 + 2 + 200 + 3;
    localparam logic [31:0] WIN_BASE   = 32'h0004_2000;
    localparam int          WIN_WORDS  = 16;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        req_valid;
    logic        req_we;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [3:0]  req_be;
    sram_data_t  sram_dq_in;
    sram_data_t  sram_dq_out;
    sram_addr_t  sram_addr;
    logic        ce_n;
    logic        oe_n;
    logic        we_n;
    logic        ub_n;
    logic        lb_n;
    logic        rsp_valid;
    logic [31:0] rsp_rdata;
    logic        busy;
    logic [31:0] sim_tp;
    logic        retire;

    string       test_name = "reset";
    int          cyc = 0;
    int          val_errs = 0;
    int          other_errs = 0;
    logic [31:0] last_tp = '0;
    logic [31:0] shadow [int];     // word index to expected content.
    logic [31:0] exp_rd_q [$];
    logic [31:0] exp_tp_q [$];
    int          wr_lat_q [$];
    int          rd_edge_q [$];
    int          wr_edge_q [$];

    sim_dut u_sim_dut (
        .clk (clk), .i_rst_n (rst_n),
        .i_req_valid (req_valid), .i_req_we (req_we), .i_req_addr (req_addr),
        .i_req_wdata (req_wdata), .i_req_be (req_be),
        .i_sram_dq (sram_dq_in), .o_sram_dq (sram_dq_out), .o_sram_addr (sram_addr),
        .o_sram_ce_n (ce_n), .o_sram_oe_n (oe_n), .o_sram_we_n (we_n),
        .o_sram_ub_n (ub_n), .o_sram_lb_n (lb_n),
        .o_rsp_valid (rsp_valid), .o_rsp_rdata (rsp_rdata), .o_busy (busy),
        .o_sim_tp (sim_tp), .o_sim_retire (retire)
    );

    sram_model u_sram_model (
        .clk (clk), .i_addr (sram_addr), .i_ce_n (ce_n), .i_oe_n (oe_n), .i_we_n (we_n),
        .i_lb_n (lb_n), .i_ub_n (ub_n), .i_dq (sram_dq_out), .o_dq (sram_dq_in)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [15:0] fill_half(logic [19:0] a);
        return a[15:0] ^ {4{a[19:16]}} ^ 16'hA5C3;
    endfunction

    // reference for what a read of this word must return right now.
    function automatic logic [31:0] expect_word(logic [31:0] addr);
        int w;
        w = addr[20:2];
        if (shadow.exists(w)) return shadow[w];
        return {fill_half({addr[20:2], 1'b1}), fill_half({addr[20:2], 1'b0})};
    endfunction

    function automatic logic [31:0] merge_write(logic [31:0] old, logic [31:0] wdata,
                                                logic [3:0] be);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) res[8*i +: 8] = wdata[8*i +: 8];
        end
        return res;
    endfunction

    task automatic issue_request(input logic we, input logic [31:0] addr,
                                 input logic [31:0] wdata, input logic [3:0] be);
        @(negedge clk);
        while (busy) @(negedge clk);
        @(posedge clk);
        req_valid <= 1'b1;
        req_we    <= we;
        req_addr  <= addr;
        req_wdata <= wdata;
        req_be    <= be;
        @(posedge clk);
        req_valid <= 1'b0;
        if (!we) begin
            exp_rd_q.push_back(expect_word(addr));
        end else if (addr == `TP_ADDR) begin
            last_tp = wdata;
            exp_tp_q.push_back(wdata);
            wr_lat_q.push_back(1);
        end else begin
            shadow[int'(addr[20:2])] = merge_write(expect_word(addr), wdata, be);
            exp_tp_q.push_back(last_tp);
            wr_lat_q.push_back(3);
        end
    endtask

    // strobe on the cycle right after an accepted request, while the port is busy.
    task automatic strobe_while_busy(input logic [31:0] addr, input logic [31:0] wdata);
        @(posedge clk);
        req_valid <= 1'b1;
        req_we    <= 1'b1;
        req_addr  <= addr;
        req_wdata <= wdata;
        req_be    <= 4'hF;
        @(negedge clk);
        assert (busy) else begin
            other_errs++;
            $display("%s: port was idle when the extra strobe was given", test_name);
        end
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic expect_pins_parked(input int cycles, input bit also_idle);
        repeat (cycles) begin
            @(negedge clk);
            assert (ce_n && oe_n && we_n && lb_n && ub_n &&
                    (!also_idle || (!busy && !rsp_valid && !retire))) else begin
                other_errs++;
                $display("%s: SRAM pins or status moved while nothing was pending", test_name);
            end
        end
    endtask

    always @(negedge clk) begin : compare
        logic [31:0] exp;
        int          edge_no;
        if (rst_n) begin
            if (req_valid && !busy) begin
                if (req_we) wr_edge_q.push_back(cyc + 1);
                else rd_edge_q.push_back(cyc + 1);
            end
            if (rsp_valid) begin
                if (exp_rd_q.size() == 0) begin
                    other_errs++;
                    $display("%s: read response with no read outstanding", test_name);
                end else begin
                    exp     = exp_rd_q.pop_front();
                    edge_no = rd_edge_q.pop_front();
                    assert (rsp_rdata === exp) else begin
                        val_errs++;
                        $display("ERROR %s: read data expected %h actual %h",
                                 test_name, exp, rsp_rdata);
                    end
                    assert (cyc - edge_no == 3) else begin
                        val_errs++;
                        $display("ERROR %s: read latency expected 3 actual %0d",
                                 test_name, cyc - edge_no);
                    end
                end
            end
            if (retire) begin
                if (exp_tp_q.size() == 0) begin
                    other_errs++;
                    $display("%s: retire pulse with no write outstanding", test_name);
                end else begin
                    exp     = exp_tp_q.pop_front();
                    edge_no = wr_edge_q.pop_front();
                    assert (sim_tp === exp) else begin
                        val_errs++;
                        $display("ERROR %s: test point expected %h actual %h",
                                 test_name, exp, sim_tp);
                    end
                    assert (cyc - edge_no == wr_lat_q[0]) else begin
                        val_errs++;
                        $display("ERROR %s: retire latency expected %0d actual %0d",
                                 test_name, wr_lat_q[0], cyc - edge_no);
                    end
                    void'(wr_lat_q.pop_front());
                end
            end
        end
    end

    initial begin
        #(4 * NUM_REQ * 5 * CLK_PERIOD);
        $display("timeout: requests still pending after %0d ns", 4 * NUM_REQ * 5 * CLK_PERIOD);
        $display("value errors: %0d, other errors: %0d", val_errs, other_errs);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        logic        we;
        logic [31:0] addrs [$];
        void'($urandom(32'h99be9c79));
        rst_n     <= 1'b0;
        req_valid <= 1'b0;
        req_we    <= 1'b0;
        req_addr  <= '0;
        req_wdata <= '0;
        req_be    <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "idle_after_reset";
        expect_pins_parked(6, 1'b1);

        test_name = "write_then_read";
        for (int i = 0; i < 4; i++) begin
            issue_request(1'b1, WIN_BASE + 4 * i, $urandom, 4'hF);
            issue_request(1'b0, WIN_BASE + 4 * i, '0, '0);
        end

        test_name = "byte_enables";
        for (int i = 0; i < 12; i++) begin
            addr = WIN_BASE + 4 * ($urandom % WIN_WORDS);
            addrs.push_back(addr);
            issue_request(1'b1, addr, $urandom, $urandom % 16);
        end
        foreach (addrs[i]) issue_request(1'b0, addrs[i], '0, '0);

        test_name = "test_point";
        repeat (2) begin
            issue_request(1'b1, `TP_ADDR, $urandom, 4'hF);
            expect_pins_parked(3, 1'b0);
        end

        test_name = "random_mix";
        for (int i = 0; i < 200; i++) begin
            we   = $urandom % 2;
            addr = WIN_BASE + 4 * ($urandom % WIN_WORDS);
            if (we && ($urandom % 16 == 0)) addr = `TP_ADDR;
            issue_request(we, addr, $urandom, $urandom % 16);
        end

        test_name = "strobe_while_busy";
        data = $urandom;
        issue_request(1'b1, WIN_BASE, data, 4'hF);
        strobe_while_busy(WIN_BASE, ~data);
        issue_request(1'b0, WIN_BASE, '0, '0);

        while (exp_rd_q.size() != 0 || exp_tp_q.size() != 0) @(negedge clk);
        repeat (6) @(negedge clk);    // catch any stray pulse.
        $display("value errors: %0d, other errors: %0d", val_errs, other_errs);
        if (val_errs + other_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+logic
logic/mem_sys_pkg.sv
logic/sram_read_seq.sv
logic/sram_write_seq.sv
logic/sram_pin_mux.sv
logic/mem_sys_top.sv
logic/sim_dut.sv
verification/sram_model.sv
verification/tb_sim_dut.sv
